//--- common/icache_pkg.sv
package icache_pkg;

    // address split seen by the L1 instruction cache
    localparam int TAG_W   = 52;
    localparam int INDEX_W = 6;
    localparam int LINES   = 1 << INDEX_W;  // one tag entry per index value

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // one stored line of the tag array
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // request held by the lookup stage while the access is in progress
    typedef struct packed {
        logic   valid;  // high for the single decision cycle
        tag_t   tag;
        index_t index;
    } lookup_req_t;

    // refill write from the resolve stage into the tag store
    typedef struct packed {
        logic   we;
        index_t index;
        tag_t   tag;
    } fill_t;

endpackage

//--- hw/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic              clk,
    input  logic              nrst,
    input  logic              read_c_l1,
    input  icache_pkg::tag_t   tag,
    input  icache_pkg::index_t index,
    input  logic              flush,
    input  logic              ready_l2_l1,
    output logic              stall,
    output logic              hit,
    output logic              read_l1_l2,
    output logic              refill
);

    icache_pkg::lookup_req_t req;
    icache_pkg::index_t      rd_index;
    icache_pkg::tag_entry_t  entry;
    icache_pkg::fill_t       fill;
    logic                    busy;  // a miss is outstanding towards L2

    // stage 1 captures the core request
    icache_lookup u_icache_lookup (
        .clk       (clk),
        .nrst      (nrst),
        .read_c_l1 (read_c_l1),
        .tag       (tag),
        .index     (index),
        .busy      (busy),
        .req       (req),
        .rd_index  (rd_index)
    );

    icache_tag_store u_icache_tag_store (
        .clk      (clk),
        .nrst     (nrst),
        .rd_index (rd_index),
        .entry    (entry),
        .fill     (fill),
        .flush    (flush)
    );

    // stage 2 decides hit or miss and talks to L2
    icache_resolve u_icache_resolve (
        .clk         (clk),
        .nrst        (nrst),
        .req         (req),
        .entry       (entry),
        .ready_l2_l1 (ready_l2_l1),
        .fill        (fill),
        .busy        (busy),
        .stall       (stall),
        .hit         (hit),
        .read_l1_l2  (read_l1_l2),
        .refill      (refill)
    );

endmodule

//--- hw/icache_lookup.sv
`timescale 1ns/1ns

module icache_lookup (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    read_c_l1,
    input  icache_pkg::tag_t         tag,
    input  icache_pkg::index_t       index,
    input  logic                    busy,
    output icache_pkg::lookup_req_t req,
    output icache_pkg::index_t       rd_index
);

    logic               valid_q;
    icache_pkg::tag_t   tag_q;
    icache_pkg::index_t index_q;
    logic               accept;

    // strobes that arrive while the core is stalled are dropped here
    assign accept = read_c_l1 && !valid_q && !busy;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;  // only lives for the decision cycle
        end
    end

    // tag and index stay put through a miss since resolve builds the fill from them
    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q   <= tag;
            index_q <= index;
        end
    end

    assign req.valid = valid_q;
    assign req.tag   = tag_q;
    assign req.index = index_q;

    assign rd_index = index_q;  // tag store is read with the captured index

    // resolve may only go busy straight after a decision cycle of this stage
    a_busy_after_req: assert property (
        @(posedge clk) disable iff (!nrst)
        $rose(busy) |-> $past(valid_q)
    ) else $error("resolve went busy without a request from lookup");

endmodule

//--- hw/icache_resolve.sv
`timescale 1ns/1ns

module icache_resolve (
    input  logic                    clk,
    input  logic                    nrst,
    input  icache_pkg::lookup_req_t req,
    input  icache_pkg::tag_entry_t  entry,
    input  logic                    ready_l2_l1,
    output icache_pkg::fill_t       fill,
    output logic                    busy,
    output logic                    stall,
    output logic                    hit,
    output logic                    read_l1_l2,
    output logic                    refill
);

    logic tag_match;
    logic miss_pending;
    logic hit_q;
    logic refill_q;
    logic fill_done;

    assign tag_match = entry.valid && (entry.tag == req.tag);

    // L2 only ends a miss that is actually outstanding
    assign fill_done = miss_pending && ready_l2_l1;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            miss_pending <= 1'b0;
        end else if (req.valid && !tag_match) begin
            miss_pending <= 1'b1;
        end else if (fill_done) begin
            miss_pending <= 1'b0;
        end
    end

    // hit and refill are single cycle pulses
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hit_q    <= 1'b0;
            refill_q <= 1'b0;
        end else begin
            hit_q    <= req.valid && tag_match;
            refill_q <= fill_done;
        end
    end

    // the held request supplies tag and index for the refill write
    assign fill.we    = fill_done;
    assign fill.index = req.index;
    assign fill.tag   = req.tag;

    assign busy       = miss_pending;
    assign read_l1_l2 = miss_pending;  // level request until L2 answers
    assign hit        = hit_q;
    assign refill     = refill_q;

    // core waits during the decision cycle and the whole miss
    assign stall = req.valid || miss_pending;

    a_hit_not_with_miss: assert property (
        @(posedge clk) disable iff (!nrst)
        !(hit && read_l1_l2)
    ) else $error("hit raised while an L2 request was pending");

    // the refill cycle has the L2 request closed and the core released
    a_refill_releases: assert property (
        @(posedge clk) disable iff (!nrst)
        refill |-> !read_l1_l2 && !stall
    ) else $error("L2 request or stall still up during refill");

endmodule

//--- hw/icache_tag_store.sv
`timescale 1ns/1ns

module icache_tag_store (
    input  logic                   clk,
    input  logic                   nrst,
    input  icache_pkg::index_t      rd_index,
    output icache_pkg::tag_entry_t entry,
    input  icache_pkg::fill_t      fill,
    input  logic                   flush
);

    logic [icache_pkg::LINES-1:0] valid_q;
    icache_pkg::tag_t             tag_mem [icache_pkg::LINES];

    // valid bits: reset and flush clear all of them at once
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;  // flush beats a refill in the same cycle
        end else if (fill.we) begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    // the tag itself is harmless to write, the line stays invalid after a flush
    always_ff @(posedge clk) begin
        if (fill.we) begin
            tag_mem[fill.index] <= fill.tag;
        end
    end

    // asynchronous read so resolve can compare in the cycle after capture
    assign entry.valid = valid_q[rd_index];
    assign entry.tag   = tag_mem[rd_index];

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the icache controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

TOP=tb_icache_ctrl
BUILD_DIR=obj_dir

echo "building ${TOP}"
verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    -f verilog.f \
    --top-module "${TOP}" \
    --Mdir "${BUILD_DIR}" \
    -o "${TOP}"

echo "running ${TOP}"
# a $fatal in the testbench gives a non-zero exit status, which set -e passes on
"./${BUILD_DIR}/${TOP}"

echo "simulation finished"

//--- test/tb_icache_model.svh
`ifndef TB_ICACHE_MODEL_SVH
`define TB_ICACHE_MODEL_SVH

// shadow copy of the tag array, updated at the same clock edges as the DUT
logic             model_valid [icache_pkg::LINES];
icache_pkg::tag_t model_tag   [icache_pkg::LINES];

// reset and flush both leave every line invalid
function automatic void clear_lines();
    int k;
    for (k = 0; k < icache_pkg::LINES; k++) begin
        model_valid[k] = 1'b0;
    end
endfunction

// a refill stores the requested tag and makes the line usable
function automatic void fill_line(
    input icache_pkg::index_t i,
    input icache_pkg::tag_t   t
);
    model_tag[i]   = t;
    model_valid[i] = 1'b1;
endfunction

// expected outcome of a read, taken from the state before the deciding edge
function automatic logic predict_hit(
    input icache_pkg::tag_t   t,
    input icache_pkg::index_t i
);
    logic line_ok;
    line_ok = model_valid[i];
    if (!line_ok) begin
        return 1'b0;  // cold or flushed line always goes to L2
    end
    return (model_tag[i] == t);
endfunction

`endif

//--- test/tb_icache_ctrl.sv
`timescale 1ns/1ns

module tb_icache_ctrl;

    localparam int MAX_CYCLES = 4000;  // 200 random accesses at up to 12 cycles plus directed
    localparam int RANDOM_READS = 200;
    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_DECIDE = 2'd1;
    localparam logic [1:0] PH_MISS = 2'd2;
    localparam icache_pkg::tag_t TAG_A = 52'hABCDEF0123456;
    localparam icache_pkg::tag_t TAG_B = 52'h3141592653589;

    logic clk;
    logic nrst;
    logic read_c_l1;
    icache_pkg::tag_t tag;
    icache_pkg::index_t index;
    logic flush;
    logic ready_l2_l1;
    logic stall;
    logic hit;
    logic read_l1_l2;
    logic refill;

    logic [1:0] phase = PH_IDLE;
    icache_pkg::tag_t cur_tag;
    icache_pkg::index_t cur_index;
    logic exp_hit = 1'b0;
    logic exp_refill = 1'b0;
    logic exp_req;
    logic exp_stall;
    logic last_hit = 1'b0;
    int hit_count = 0;
    int miss_count = 0;
    int reads_issued = 0;
    int cycle_count = 0;
    icache_pkg::tag_t tag_pool [4];

    `include "tb_icache_model.svh"

    icache_ctrl u_icache_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .read_c_l1   (read_c_l1),
        .tag         (tag),
        .index       (index),
        .flush       (flush),
        .ready_l2_l1 (ready_l2_l1),
        .stall       (stall),
        .hit         (hit),
        .read_l1_l2  (read_l1_l2),
        .refill      (refill)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic got, input logic want);
        string line;
        if (got !== want) begin
            line = $sformatf("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, want);
            fail_run(line);
        end
    endtask

    // expected protocol state, advanced from the inputs sampled at each rising edge
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            phase = PH_IDLE;
            exp_hit = 1'b0;
            exp_refill = 1'b0;
            clear_lines();
        end else begin
            exp_hit = 1'b0;
            exp_refill = 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (read_c_l1) begin
                        cur_tag = tag;
                        cur_index = index;
                        phase = PH_DECIDE;
                    end
                end
                PH_DECIDE: begin
                    last_hit = predict_hit(cur_tag, cur_index);
                    if (last_hit) begin
                        exp_hit = 1'b1;
                        hit_count++;
                        phase = PH_IDLE;
                    end else begin
                        miss_count++;
                        phase = PH_MISS;
                    end
                end
                default: begin
                    if (ready_l2_l1) begin  // ready outside a miss is ignored
                        fill_line(cur_index, cur_tag);
                        exp_refill = 1'b1;
                        phase = PH_IDLE;
                    end
                end
            endcase
            // a flush on the refill edge wins, so it is applied after the fill
            if (flush) begin
                clear_lines();
            end
        end
    end

    assign exp_stall = (phase != PH_IDLE);
    assign exp_req = (phase == PH_MISS);

    always @(negedge clk) begin
        check_value("hit", hit, exp_hit);
        check_value("read_l1_l2", read_l1_l2, exp_req);
        check_value("refill", refill, exp_refill);
        check_value("stall", stall, exp_stall);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            fail_run("timeout: the test did not finish within the cycle limit");
        end
    end

    // L2 answers a miss after 0 to 5 cycles and now and then sends a stray ready
    initial begin : l2_responder
        int delay;
        logic [31:0] r;
        ready_l2_l1 = 1'b0;
        forever begin
            @(negedge clk);
            r = $urandom;
            if (read_l1_l2) begin
                delay = int'(r % 6);
                repeat (delay) begin
                    @(negedge clk);
                end
                ready_l2_l1 = 1'b1;
                @(negedge clk);
                ready_l2_l1 = 1'b0;
            end else if (nrst && r[7:3] == 5'd0) begin
                ready_l2_l1 = 1'b1;
                @(negedge clk);
                ready_l2_l1 = 1'b0;
            end
        end
    end

    task automatic read_and_wait(
        input icache_pkg::tag_t t,
        input icache_pkg::index_t i,
        input logic hit_expected
    );
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        read_c_l1 = 1'b1;
        tag = t;
        index = i;
        reads_issued++;
        @(negedge clk);
        read_c_l1 = 1'b0;
        while (stall) begin
            @(negedge clk);
        end
        check_value("outcome of directed read", last_hit, hit_expected);
    endtask

    task automatic flush_idle();
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // strobes while stalled must be dropped without any response
    task automatic random_run(input int n_reads);
        logic [31:0] r;
        int accepted;
        accepted = 0;
        while (accepted < n_reads) begin
            @(negedge clk);
            r = $urandom;
            flush = (r[7:4] == 4'd0);
            tag = tag_pool[r[9:8]];
            index = {r[12:10], 3'b101};
            if (!stall) begin
                read_c_l1 = (r[2:0] != 3'd0);
                if (read_c_l1) begin
                    accepted++;
                    reads_issued++;
                end
            end else begin
                read_c_l1 = (r[1:0] == 2'd0);
            end
        end
        @(negedge clk);
        read_c_l1 = 1'b0;
        flush = 1'b0;
        while (stall) begin
            @(negedge clk);
        end
        repeat (2) begin
            @(negedge clk);
        end
    endtask

    initial begin
        logic [63:0] r64;
        int k;
        nrst = 1'b0;
        read_c_l1 = 1'b0;
        tag = '0;
        index = '0;
        flush = 1'b0;
        void'($urandom(32'h5a02f7e2));
        for (k = 0; k < 4; k++) begin
            r64 = {$urandom, $urandom};
            tag_pool[k] = r64[51:0];
        end
        repeat (2) begin
            @(posedge clk);
        end
        @(negedge clk);
        nrst = 1'b1;

        read_and_wait(TAG_A, 6'd10, 1'b0);  // cold line
        read_and_wait(TAG_A, 6'd10, 1'b1);
        read_and_wait(TAG_B, 6'd10, 1'b0);  // replaces the line
        read_and_wait(TAG_A, 6'd10, 1'b0);
        read_and_wait(TAG_B, 6'd20, 1'b0);
        read_and_wait(TAG_B, 6'd20, 1'b1);
        flush_idle();
        read_and_wait(TAG_A, 6'd10, 1'b0);
        read_and_wait(TAG_B, 6'd20, 1'b0);

        random_run(RANDOM_READS);

        if (hit_count + miss_count == reads_issued && hit_count > 0 && miss_count > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("accepted reads do not add up, or hits and misses were not both seen");
        end
    end

endmodule

//--- verilog.f
+incdir+test
common/icache_pkg.sv
hw/icache_lookup.sv
hw/icache_tag_store.sv
hw/icache_resolve.sv
hw/icache_ctrl.sv
test/tb_icache_ctrl.sv
